// File: source/alu_pkg.sv
// shared types for the streaming 16-bit ALU
// widths, opcode encoding and the structs carried between stages
package alu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int DATA_W = 16;  // operand and result width
  localparam int TAG_W  = 4;   // command tag width

  //////////////////////////////
  // opcodes
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,  // a + b
    OP_SUB = 3'd1,  // a - b
    OP_AND = 3'd2,  // bitwise and
    OP_OR  = 3'd3,  // bitwise or
    OP_XOR = 3'd4,  // bitwise xor
    OP_SHL = 3'd5,  // shift left, zero fill
    OP_SHR = 3'd6,  // logical shift right
    OP_SRA = 3'd7   // arithmetic shift right
  } op_e;

  //////////////////////////////
  // stage payloads
  //////////////////////////////

  // command as it arrives on the input port, 40 bits
  typedef struct packed {
    op_e               opcode;  // operation select
    logic              sat;     // saturate add/sub instead of wrapping
    logic [DATA_W-1:0] a;       // first operand
    logic [DATA_W-1:0] b;       // second operand
    logic [TAG_W-1:0]  tag;     // user tag, returned with the result
  } cmd_t;

  // decoded command, ready for the execute step
  typedef struct packed {
    op_e               opcode;    // kept for unit select
    logic              sat;       // passed through
    logic [DATA_W-1:0] a;         // first operand
    logic [DATA_W-1:0] b;         // inverted for subtract
    logic              carry_in;  // set for subtract
    logic [3:0]        shamt;     // low bits of b
    logic [TAG_W-1:0]  tag;       // passed through
  } dec_t;

  // executed item, before saturation and flags
  typedef struct packed {
    logic [DATA_W:0]  raw;  // 17-bit result, bit 16 is adder carry out
    logic             ovf;  // signed overflow of add/sub
    logic             sat;  // saturate request
    logic [TAG_W-1:0] tag;  // passed through
  } exe_t;

  // response on the output port, 23 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;     // final result
    logic              zero;     // data is all zero
    logic              ovf;      // signed overflow seen
    logic              sat_hit;  // result was clamped
    logic [TAG_W-1:0]  tag;      // tag of the command
  } rsp_t;

endpackage

// File: source/pipeline.sv
// elastic one-entry pipeline register
// valid/ready on both sides, synchronous clear empties the entry
module pipeline #(
  parameter int ELEM_WIDTH = 8  // bits per stored item
) (
  input  logic                  arst_ni,           // async reset, active low
  input  logic                  clk_i,             // clock
  input  logic                  clear_i,           // sync flush

  input  logic [ELEM_WIDTH-1:0] elem_in_i,         // incoming item
  input  logic                  elem_in_valid_i,   // incoming item valid
  output logic                  elem_in_ready_o,   // can take an item

  output logic [ELEM_WIDTH-1:0] elem_out_o,        // stored item
  output logic                  elem_out_valid_o,  // stored item valid
  input  logic                  elem_out_ready_i   // downstream can take it
);

  //////////////////////////////
  // signals
  //////////////////////////////

  logic is_full;   // entry holds an item
  logic run_q;     // high from the first edge after reset
  logic in_xfer;   // input transfer this cycle
  logic out_xfer;  // output transfer this cycle

  //////////////////////////////
  // handshake
  //////////////////////////////

  // take a new item when empty or when the held one leaves now
  assign elem_in_ready_o  = run_q & ~clear_i & (~is_full | elem_out_ready_i);
  assign elem_out_valid_o = is_full & ~clear_i;  // nothing offered during flush

  assign in_xfer  = elem_in_valid_i & elem_in_ready_o;
  assign out_xfer = elem_out_valid_o & elem_out_ready_i;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (in_xfer) begin
      elem_out_o <= elem_in_i;  // capture payload
    end
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      is_full <= 1'b0;
      run_q   <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (clear_i) begin
        is_full <= 1'b0;  // flush drops the entry
      end else begin
        case ({in_xfer, out_xfer})
          2'b10, 2'b11: is_full <= 1'b1;  // filled, or refilled as it drains
          2'b01:        is_full <= 1'b0;  // drained with no refill
          default:      is_full <= is_full;
        endcase
      end
    end
  end

endmodule

// File: source/op_decode.sv
// command decode for the streaming ALU
// prepares adder operands and shift amount from a raw command
module op_decode
  import alu_pkg::*;
(
  input  cmd_t cmd_i,  // command from the input port
  output dec_t dec_o   // decoded command to stage s0
);

  //////////////////////////////
  // operand preparation
  //////////////////////////////

  logic [DATA_W-1:0] b_prep;   // b as the adder wants it
  logic              cin;      // adder carry in
  logic [3:0]        shamt;    // shift distance

  always_comb begin
    b_prep = cmd_i.b;  // plain second operand for every other op
    cin    = 1'b0;
    if (cmd_i.opcode == OP_SUB) begin
      b_prep = ~cmd_i.b;  // a + ~b + 1 == a - b
      cin    = 1'b1;
    end
  end

  assign shamt = cmd_i.b[3:0];  // from the original b, never inverted

  //////////////////////////////
  // decoded output
  //////////////////////////////

  always_comb begin
    dec_o          = '0;
    dec_o.opcode   = cmd_i.opcode;
    dec_o.sat      = cmd_i.sat;  // format step decides clamping
    dec_o.a        = cmd_i.a;
    dec_o.b        = b_prep;
    dec_o.carry_in = cin;
    dec_o.shamt    = shamt;
    dec_o.tag      = cmd_i.tag;  // travels with the item
  end

endmodule

// File: source/op_execute.sv
// execute step of the streaming ALU
// shared add/sub adder, logic unit and barrel shifter with overflow detect
module op_execute
  import alu_pkg::*;
(
  input  dec_t dec_i,  // decoded command from s0
  output exe_t exe_o   // raw result to stage s1
);

  //////////////////////////////
  // adder
  //////////////////////////////

  logic [DATA_W:0]   sum;        // 17 bits, msb is carry out
  logic              add_ovf;    // signed overflow of the sum
  logic              same_sign;  // operand sign bits agree

  // zero-extended so bit 16 is the carry, b already inverted for sub
  assign sum = {1'b0, dec_i.a} + {1'b0, dec_i.b} + {{DATA_W{1'b0}}, dec_i.carry_in};

  assign same_sign = ~(dec_i.a[DATA_W-1] ^ dec_i.b[DATA_W-1]);
  assign add_ovf   = same_sign & (sum[DATA_W-1] ^ dec_i.a[DATA_W-1]);  // sign flipped

  //////////////////////////////
  // logic unit
  //////////////////////////////

  logic [DATA_W-1:0] and_res;  // a & b
  logic [DATA_W-1:0] or_res;   // a | b
  logic [DATA_W-1:0] xor_res;  // a ^ b

  assign and_res = dec_i.a & dec_i.b;
  assign or_res  = dec_i.a | dec_i.b;
  assign xor_res = dec_i.a ^ dec_i.b;

  //////////////////////////////
  // shifter
  //////////////////////////////

  logic [DATA_W-1:0] shl_res;  // zero fill from the right
  logic [DATA_W-1:0] shr_res;  // zero fill from the left
  logic [DATA_W-1:0] sra_res;  // sign fill from the left

  assign shl_res = dec_i.a << dec_i.shamt;
  assign shr_res = dec_i.a >> dec_i.shamt;
  assign sra_res = $signed(dec_i.a) >>> dec_i.shamt;  // replicate a[15]

  //////////////////////////////
  // result select
  //////////////////////////////

  logic [DATA_W:0] raw;  // selected 17-bit result
  logic            ovf;  // overflow, add/sub only

  always_comb begin
    raw = '0;
    ovf = 1'b0;
    unique case (dec_i.opcode)
      OP_ADD,
      OP_SUB: begin
        raw = sum;  // keep carry for clamp sign
        ovf = add_ovf;
      end
      OP_AND:  raw = {1'b0, and_res};
      OP_OR:   raw = {1'b0, or_res};
      OP_XOR:  raw = {1'b0, xor_res};
      OP_SHL:  raw = {1'b0, shl_res};
      OP_SHR:  raw = {1'b0, shr_res};
      OP_SRA:  raw = {1'b0, sra_res};
      default: raw = '0;
    endcase
  end

  always_comb begin
    exe_o     = '0;
    exe_o.raw = raw;
    exe_o.ovf = ovf;
    exe_o.sat = dec_i.sat;  // passed through
    exe_o.tag = dec_i.tag;
  end

endmodule

// File: source/result_format.sv
// result format step of the streaming ALU
// applies saturation and builds the response with zero and overflow flags
module result_format
  import alu_pkg::*;
(
  input  exe_t exe_i,  // executed item from s1
  output rsp_t rsp_o   // response to stage s2
);

  //////////////////////////////
  // saturation
  //////////////////////////////

  localparam logic [DATA_W-1:0] MAX_POS = {1'b0, {(DATA_W-1){1'b1}}};  // 0x7fff
  localparam logic [DATA_W-1:0] MIN_NEG = {1'b1, {(DATA_W-1){1'b0}}};  // 0x8000

  logic              clamp;     // saturate this item
  logic              a_nonneg;  // sign of a on overflow
  logic [DATA_W-1:0] clamped;   // limit value
  logic [DATA_W-1:0] data;      // final data

  assign clamp = exe_i.sat & exe_i.ovf;

  // on overflow the carry out is set exactly when a was negative
  assign a_nonneg = ~exe_i.raw[DATA_W];

  assign clamped = a_nonneg ? MAX_POS : MIN_NEG;
  assign data    = clamp ? clamped : exe_i.raw[DATA_W-1:0];  // wrap by truncation

  //////////////////////////////
  // response
  //////////////////////////////

  always_comb begin
    rsp_o         = '0;
    rsp_o.data    = data;
    rsp_o.zero    = (data == '0);  // after clamping
    rsp_o.ovf     = exe_i.ovf;     // reported even when clamped
    rsp_o.sat_hit = clamp;
    rsp_o.tag     = exe_i.tag;
  end

endmodule

// File: source/alu_stream_top.sv
// streaming 16-bit integer ALU
// decode, execute and format steps split by three elastic registers
module alu_stream_top
  import alu_pkg::*;
(
  input  logic clk_i,        // clock
  input  logic arst_ni,      // async reset, active low
  input  logic clear_i,      // sync flush of all stages

  input  cmd_t cmd_i,        // command in
  input  logic cmd_valid_i,  // command valid
  output logic cmd_ready_o,  // ALU can take a command

  output rsp_t rsp_o,        // response out
  output logic rsp_valid_o,  // response valid
  input  logic rsp_ready_i   // sink can take a response
);

  //////////////////////////////
  // stage links
  //////////////////////////////

  dec_t dec_d;     // decode result into s0
  dec_t dec_q;     // s0 output
  logic s0_valid;  // s0 has an item
  logic s1_ready;  // s1 can take it

  exe_t exe_d;     // execute result into s1
  exe_t exe_q;     // s1 output
  logic s1_valid;  // s1 has an item
  logic s2_ready;  // s2 can take it

  rsp_t rsp_d;     // formatted response into s2

  //////////////////////////////
  // decode and s0
  //////////////////////////////

  op_decode u_decode (.cmd_i(cmd_i), .dec_o(dec_d));

  pipeline #(.ELEM_WIDTH($bits(dec_t))) s0 (
    .arst_ni, .clk_i, .clear_i,
    .elem_in_i(dec_d), .elem_in_valid_i(cmd_valid_i), .elem_in_ready_o(cmd_ready_o),
    .elem_out_o(dec_q), .elem_out_valid_o(s0_valid), .elem_out_ready_i(s1_ready)
  );

  //////////////////////////////
  // execute and s1
  //////////////////////////////

  op_execute u_execute (.dec_i(dec_q), .exe_o(exe_d));

  pipeline #(.ELEM_WIDTH($bits(exe_t))) s1 (
    .arst_ni, .clk_i, .clear_i,
    .elem_in_i(exe_d), .elem_in_valid_i(s0_valid), .elem_in_ready_o(s1_ready),
    .elem_out_o(exe_q), .elem_out_valid_o(s1_valid), .elem_out_ready_i(s2_ready)
  );

  //////////////////////////////
  // format and s2
  //////////////////////////////

  result_format u_format (.exe_i(exe_q), .rsp_o(rsp_d));

  pipeline #(.ELEM_WIDTH($bits(rsp_t))) s2 (  // drives the output port
    .arst_ni, .clk_i, .clear_i,
    .elem_in_i(rsp_d), .elem_in_valid_i(s1_valid), .elem_in_ready_o(s2_ready),
    .elem_out_o(rsp_o), .elem_out_valid_o(rsp_valid_o), .elem_out_ready_i(rsp_ready_i)
  );

endmodule

// File: tb/tb_checker.sv
// response checker for the streaming ALU testbench
// compares every output transfer in order with the expected table
module tb_checker
  import alu_pkg::*;
#(
  parameter int N_VEC = 24,  // table entries
  parameter int TOTAL = 49   // responses expected over the run
) (
  input  logic clk_i,
  input  logic arst_ni,
  input  logic clear_i,
  input  logic cmd_valid_i,
  input  logic cmd_ready_i,
  input  rsp_t rsp_i,
  input  logic rsp_valid_i,
  input  logic rsp_ready_i,
  input  logic lat_check_i,          // compare latency of this response
  input  rsp_t exp_tbl_i [N_VEC],    // expected responses, by entry
  output int   seen_o,               // responses checked so far
  output int   err_o                 // failed checks so far
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LATENCY = 3;  // input transfer to output valid

  int   cyc = 0;       // negedge count
  int   n_seen = 0;
  int   n_err = 0;
  logic rst_q = 1'b0;  // reset released at last negedge
  int   stamp_q[$];    // accept cycle of each command in flight

  assign seen_o = n_seen;
  assign err_o  = n_err;

  task automatic compare_value(input string sig, input int expv, input int gotv, inout bit bad);
    if (gotv != expv) begin
      $display("error at %0d ns: %s expected %0h, got %0h", $time, sig, expv, gotv);
      n_err++;
      bad = 1'b1;
    end
  endtask

  task automatic expect_low(input string sig, input logic val);
    if (val !== 1'b0) begin
      $display("error at %0d ns: %s expected 0, got %b", $time, sig, val);
      n_err++;
    end
  endtask

  task automatic check_response();
    rsp_t want;
    int   idx;
    int   lat;
    bit   bad;
    bad = 1'b0;
    if (n_seen >= TOTAL) begin
      $display("extra response with tag %h after all %0d expected ones", rsp_i.tag, TOTAL);
      n_err++;
    end else begin
      idx  = n_seen % N_VEC;  // table replays in order
      want = exp_tbl_i[idx];
      compare_value("rsp_o.data", int'(want.data), int'(rsp_i.data), bad);
      compare_value("rsp_o.zero", int'(want.zero), int'(rsp_i.zero), bad);
      compare_value("rsp_o.ovf", int'(want.ovf), int'(rsp_i.ovf), bad);
      compare_value("rsp_o.sat_hit", int'(want.sat_hit), int'(rsp_i.sat_hit), bad);
      compare_value("rsp_o.tag", int'(want.tag), int'(rsp_i.tag), bad);
      if (stamp_q.size() == 0) begin
        $display("response %0d arrived with no accepted command behind it", n_seen);
        n_err++;
        bad = 1'b1;
      end else begin
        lat = cyc - stamp_q.pop_front();
        if (lat_check_i && lat != LATENCY) begin
          $display("error at %0d ns: latency expected %0d, got %0d", $time, LATENCY, lat);
          n_err++;
          bad = 1'b1;
        end
      end
      n_seen++;
      $display("response %0d, entry %0d, tag %h: %s", n_seen, idx, rsp_i.tag,
               bad ? "failed" : "ok");
    end
  endtask

  //////////////////////////////
  // sampled mid-cycle, inputs and outputs are settled here
  //////////////////////////////

  always @(negedge clk_i) begin
    cyc++;
    if (!arst_ni || !rst_q) begin  // in reset and first cycle after
      expect_low("rsp_valid_o", rsp_valid_i);
      expect_low("cmd_ready_o", cmd_ready_i);
    end
    rst_q = arst_ni;
    if (clear_i) begin
      expect_low("rsp_valid_o", rsp_valid_i);
      expect_low("cmd_ready_o", cmd_ready_i);
      stamp_q.delete();  // flush drops whatever is in flight
    end
    if (cmd_valid_i && cmd_ready_i) begin
      stamp_q.push_back(cyc);
    end
    if (rsp_valid_i && rsp_ready_i) begin
      check_response();
    end
  end

endmodule

// File: tb/tb_top.sv
// testbench for the streaming ALU
// plays the command table with a ready sink, with random back-pressure, then a flush
module tb_top
  import alu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;  // 40 ns clock
  localparam int DRV_DLY      = 2;   // inputs change after the rising edge
  localparam int RST_CYCLES   = 16;
  localparam int N_VEC        = 24;
  localparam int TOTAL        = 2 * N_VEC + 1;  // two passes, one after flush
  localparam int FLUSH_CYCLES = 16;
  localparam int LIMIT        = 4 * TOTAL + RST_CYCLES + FLUSH_CYCLES;

  typedef enum logic [1:0] {READY_HIGH, READY_RAND, READY_LOW} ready_mode_e;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        clear;
  cmd_t        cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  rsp_t        rsp;
  logic        rsp_valid;
  logic        rsp_ready;
  logic        lat_check;                // checker compares latency
  ready_mode_e ready_mode = READY_HIGH;  // sink behaviour
  int          seed = 32'h62da;
  int          cycle_cnt = 0;
  int          n_fill = 0;
  int          seen_cnt;
  int          err_cnt;
  cmd_t        cmd_tbl [N_VEC];
  rsp_t        exp_tbl [N_VEC];

  always #HALF_PERIOD clk = ~clk;

  alu_stream_top dut0 (
    .clk_i(clk), .arst_ni(arst_n), .clear_i(clear),
    .cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
    .rsp_o(rsp), .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready)
  );

  tb_checker #(.N_VEC(N_VEC), .TOTAL(TOTAL)) chk0 (
    .clk_i(clk), .arst_ni(arst_n), .clear_i(clear),
    .cmd_valid_i(cmd_valid), .cmd_ready_i(cmd_ready),
    .rsp_i(rsp), .rsp_valid_i(rsp_valid), .rsp_ready_i(rsp_ready),
    .lat_check_i(lat_check), .exp_tbl_i(exp_tbl), .seen_o(seen_cnt), .err_o(err_cnt)
  );

  // sink ready, one random draw per cycle keeps the sequence fixed
  initial begin
    int rnd;
    rsp_ready = 1'b0;
    forever begin
      @(posedge clk);
      #DRV_DLY;
      rnd = $random(seed);
      case (ready_mode)
        READY_HIGH: rsp_ready = 1'b1;
        READY_RAND: rsp_ready = rnd[0];
        default:    rsp_ready = 1'b0;
      endcase
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d responses seen", LIMIT, seen_cnt, TOTAL);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic add_vec(input op_e op, input logic sat, input logic [15:0] a, b, data,
                         input logic zero, ovf, sat_hit);
    cmd_tbl[n_fill] = '{opcode: op, sat: sat, a: a, b: b, tag: 4'(n_fill)};
    exp_tbl[n_fill] = '{data: data, zero: zero, ovf: ovf, sat_hit: sat_hit, tag: 4'(n_fill)};
    n_fill++;
  endtask

  // called at a drive point, returns at the drive point after the transfer
  task automatic send_cmd(input cmd_t c);
    logic rdy;
    cmd       = c;
    cmd_valid = 1'b1;
    rdy       = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = cmd_ready;  // settled, transfer at the coming edge
      @(posedge clk);
      #DRV_DLY;
    end
  endtask

  task automatic wait_resp(input int n);
    do begin
      @(posedge clk);
    end while (seen_cnt < n);
    #DRV_DLY;
  endtask

  task automatic set_ready_mode(input ready_mode_e mode);
    @(negedge clk);
    ready_mode = mode;  // used from the next drive point
    @(posedge clk);
    #DRV_DLY;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    arst_n    = 1'b0;
    clear     = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    lat_check = 1'b0;
    // wrapping add/sub
    add_vec(OP_ADD, 1'b0, 16'h0001, 16'h0002, 16'h0003, 1'b0, 1'b0, 1'b0);
    add_vec(OP_ADD, 1'b0, 16'h7fff, 16'h0001, 16'h8000, 1'b0, 1'b1, 1'b0);
    add_vec(OP_ADD, 1'b0, 16'hffff, 16'h0001, 16'h0000, 1'b1, 1'b0, 1'b0);
    add_vec(OP_ADD, 1'b0, 16'h8000, 16'h8000, 16'h0000, 1'b1, 1'b1, 1'b0);
    add_vec(OP_SUB, 1'b0, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0);
    add_vec(OP_SUB, 1'b0, 16'h0005, 16'h0007, 16'hfffe, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SUB, 1'b0, 16'h8000, 16'h0001, 16'h7fff, 1'b0, 1'b1, 1'b0);
    add_vec(OP_SUB, 1'b0, 16'h7fff, 16'hffff, 16'h8000, 1'b0, 1'b1, 1'b0);
    // saturating add/sub
    add_vec(OP_ADD, 1'b1, 16'h7fff, 16'h0001, 16'h7fff, 1'b0, 1'b1, 1'b1);
    add_vec(OP_ADD, 1'b1, 16'h8000, 16'h8000, 16'h8000, 1'b0, 1'b1, 1'b1);
    add_vec(OP_SUB, 1'b1, 16'h8000, 16'h0001, 16'h8000, 1'b0, 1'b1, 1'b1);
    add_vec(OP_SUB, 1'b1, 16'h7fff, 16'hffff, 16'h7fff, 1'b0, 1'b1, 1'b1);
    add_vec(OP_ADD, 1'b1, 16'h1234, 16'h1111, 16'h2345, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SUB, 1'b1, 16'h0003, 16'h0003, 16'h0000, 1'b1, 1'b0, 1'b0);
    // logic and shifts, shift amount from b[3:0]
    add_vec(OP_AND, 1'b0, 16'hf0f0, 16'h3c3c, 16'h3030, 1'b0, 1'b0, 1'b0);
    add_vec(OP_OR,  1'b0, 16'hf0f0, 16'h0f00, 16'hfff0, 1'b0, 1'b0, 1'b0);
    add_vec(OP_XOR, 1'b0, 16'haaaa, 16'haaaa, 16'h0000, 1'b1, 1'b0, 1'b0);
    add_vec(OP_XOR, 1'b0, 16'h1234, 16'hffff, 16'hedcb, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SHL, 1'b0, 16'h0001, 16'h0004, 16'h0010, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SHL, 1'b0, 16'h8001, 16'h0011, 16'h0002, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SHR, 1'b0, 16'h8000, 16'h000f, 16'h0001, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SHR, 1'b0, 16'hf0f0, 16'h0104, 16'h0f0f, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SRA, 1'b1, 16'h8000, 16'h0003, 16'hf000, 1'b0, 1'b0, 1'b0);
    add_vec(OP_SRA, 1'b0, 16'h7000, 16'h0004, 16'h0700, 1'b0, 1'b0, 1'b0);

    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DLY;
    arst_n = 1'b1;

    lat_check = 1'b1;  // sink always ready here
    for (int i = 0; i < N_VEC; i++) begin
      send_cmd(cmd_tbl[i]);
    end
    cmd_valid = 1'b0;
    wait_resp(N_VEC);
    lat_check = 1'b0;

    set_ready_mode(READY_RAND);  // replay under back-pressure
    for (int i = 0; i < N_VEC; i++) begin
      send_cmd(cmd_tbl[i]);
    end
    cmd_valid = 1'b0;
    wait_resp(2 * N_VEC);

    set_ready_mode(READY_LOW);  // stall three commands, then flush them
    for (int i = 5; i < 8; i++) begin
      send_cmd(cmd_tbl[i]);
    end
    cmd_valid = 1'b0;
    clear     = 1'b1;
    @(posedge clk);
    #DRV_DLY;
    clear = 1'b0;
    set_ready_mode(READY_HIGH);
    repeat (4) @(posedge clk);  // nothing may come out now
    #DRV_DLY;
    lat_check = 1'b1;
    send_cmd(cmd_tbl[0]);
    cmd_valid = 1'b0;
    wait_resp(TOTAL);
    repeat (4) @(posedge clk);  // room for a stray response

    $display("checked %0d of %0d responses, %0d errors", seen_cnt, TOTAL, err_cnt);
    if (err_cnt == 0 && seen_cnt == TOTAL) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
source/alu_pkg.sv
source/pipeline.sv
source/op_decode.sv
source/op_execute.sv
source/result_format.sv
source/alu_stream_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
